/* common/core_pkg.sv */
// Mini core shared definitions

package core_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int instr_width   = 24;
  localparam int data_width    = 16;
  // pc counts instructions, not bytes
  localparam int pc_width      = 8;
  localparam int reg_count     = 8;
  localparam int reg_idx_width = 3;
  localparam int imm_width     = 8;
  localparam int opcode_width  = 4;

  // --------------------
  // instruction fields
  // --------------------
  localparam int opcode_msb = 23;
  localparam int opcode_lsb = 20;
  localparam int rd_msb     = 19;
  localparam int rd_lsb     = 17;
  localparam int rs1_msb    = 16;
  localparam int rs1_lsb    = 14;
  localparam int rs2_msb    = 13;
  localparam int rs2_lsb    = 11;
  // bits 10..8 are not used by any opcode
  localparam int imm_msb    = 7;
  localparam int imm_lsb    = 0;

  // opcodes, anything else is treated as nop
  typedef enum logic [opcode_width-1:0] {
    op_nop     = 4'd0,
    op_add     = 4'd1,
    op_sub     = 4'd2,
    op_addi    = 4'd3,
    op_beq     = 4'd4,
    op_bne     = 4'd5,
    op_fence_i = 4'd6
  } op_e;

  // --------------------
  // maintenance FSMs
  // --------------------
  typedef enum logic [1:0] {
    fencei_idle,
    fencei_invalidating,
    // one of icache / dcache has answered
    fencei_half_done
  } fencei_state_e;

  typedef enum logic [2:0] {
    dump_idle,
    dump_before_dcache,
    dump_wait_dcache,
    dump_before_l2,
    dump_wait_l2,
    dump_finish
  } dump_state_e;

endpackage

/* common/decoded_op_if.sv */
// Decoded instruction link

interface decoded_op_if;
  import core_pkg::*;

  // one decoded instruction, decode -> execute
  logic                     valid;
  op_e                      op;
  logic [reg_idx_width-1:0] rd;
  logic [reg_idx_width-1:0] rs1;
  logic [reg_idx_width-1:0] rs2;
  // already sign extended
  logic [data_width-1:0]    imm;
  logic [pc_width-1:0]      pc;

  modport producer (
    output valid, op, rd, rs1, rs2, imm, pc
  );

  modport consumer (
    input valid, op, rd, rs1, rs2, imm, pc
  );

endinterface

/* common/operand_if.sv */
// Register source read link

interface operand_if;
  import core_pkg::*;

  // source indices from execute
  logic [reg_idx_width-1:0] rs1;
  logic [reg_idx_width-1:0] rs2;
  // values come back in the same cycle
  logic [data_width-1:0]    rs1_value;
  logic [data_width-1:0]    rs2_value;

  modport requester (output rs1, rs2, input rs1_value, rs2_value);

  modport provider (input rs1, rs2, output rs1_value, rs2_value);

endinterface

/* pipeline/decode_stage.sv */
// Instruction decode stage

module decode_stage (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             instr_valid,
  input  logic [core_pkg::instr_width-1:0] instr,
  input  logic [core_pkg::pc_width-1:0]    instr_pc,
  input  logic                             hold_front,
  input  logic                             maint_busy,
  output logic                             instr_ready,
  decoded_op_if.producer                   decoded
);
  import core_pkg::*;

  logic                   accept;
  logic [imm_width-1:0]   raw_imm;
  logic [data_width-1:0]  imm_ext;
  op_e                    op_next;

  // map raw opcode bits, unknown codes become nop
  function automatic op_e decode_opcode(input logic [opcode_width-1:0] code);
    op_e op;
    case (code)
      op_add, op_sub, op_addi, op_beq, op_bne, op_fence_i: op = op_e'(code);
      default: op = op_nop;
    endcase
    return op;
  endfunction

  // --------------------
  // input handshake
  // --------------------
  // branch / fence in execute, or cache maintenance running
  assign instr_ready = !(hold_front || maint_busy);
  assign accept      = instr_valid && instr_ready;

  // --------------------
  // field extraction
  // --------------------
  assign op_next = decode_opcode(instr[opcode_msb:opcode_lsb]);
  assign raw_imm = instr[imm_msb:imm_lsb];
  // sign extend to register width
  assign imm_ext = {{(data_width - imm_width){raw_imm[imm_width-1]}}, raw_imm};

  // valid bit, empties when nothing was taken
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      decoded.valid <= 1'b0;
    end else begin
      decoded.valid <= accept;
    end
  end

  // payload only loads on acceptance
  always_ff @(posedge clock) begin
    if (accept) begin
      decoded.op  <= op_next;
      decoded.rd  <= instr[rd_msb:rd_lsb];
      decoded.rs1 <= instr[rs1_msb:rs1_lsb];
      decoded.rs2 <= instr[rs2_msb:rs2_lsb];
      decoded.imm <= imm_ext;
      decoded.pc  <= instr_pc;
    end
  end

endmodule

/* pipeline/execute_stage.sv */
// Execute and branch resolution

module execute_stage (
  decoded_op_if.consumer                     decoded,
  operand_if.requester                       operands,
  output logic                               result_valid,
  output logic [core_pkg::reg_idx_width-1:0] result_rd,
  output logic [core_pkg::data_width-1:0]    result_data,
  output logic                               redirect_valid,
  output logic [core_pkg::pc_width-1:0]      redirect_pc,
  output logic                               hold_front,
  output logic                               fence_start
);
  import core_pkg::*;

  logic [data_width-1:0] alu_out;
  logic                  is_alu;
  logic                  operands_equal;
  logic                  branch_taken;

  // --------------------
  // operand reads
  // --------------------
  assign operands.rs1 = decoded.rs1;
  assign operands.rs2 = decoded.rs2;

  assign operands_equal = (operands.rs1_value == operands.rs2_value);

  // --------------------
  // arithmetic
  // --------------------
  always_comb begin
    alu_out = '0;
    is_alu  = 1'b0;
    case (decoded.op)
      op_add: begin
        alu_out = operands.rs1_value + operands.rs2_value;
        is_alu  = 1'b1;
      end
      op_sub: begin
        alu_out = operands.rs1_value - operands.rs2_value;
        is_alu  = 1'b1;
      end
      op_addi: begin
        // wraps at 16 bits
        alu_out = operands.rs1_value + decoded.imm;
        is_alu  = 1'b1;
      end
      default: ;
    endcase
  end

  // writes to r0 are dropped here
  assign result_valid = decoded.valid && is_alu && (decoded.rd != '0);
  assign result_rd    = decoded.rd;
  assign result_data  = alu_out;

  // --------------------
  // branches
  // --------------------
  always_comb begin
    branch_taken = 1'b0;
    if (decoded.valid) begin
      case (decoded.op)
        op_beq:  branch_taken = operands_equal;
        op_bne:  branch_taken = !operands_equal;
        default: branch_taken = 1'b0;
      endcase
    end
  end

  assign redirect_valid = branch_taken;
  // target wraps modulo the pc range
  assign redirect_pc    = decoded.pc + decoded.imm[pc_width-1:0];

  // fence.i kicks the maintenance FSM
  assign fence_start = decoded.valid && (decoded.op == op_fence_i);

  // block the front end while a redirect or fence sits here
  assign hold_front = branch_taken || fence_start;

endmodule

/* pipeline/writeback_stage.sv */
// Writeback and register file

module writeback_stage (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               result_valid,
  input  logic [core_pkg::reg_idx_width-1:0] result_rd,
  input  logic [core_pkg::data_width-1:0]    result_data,
  operand_if.provider                        operands,
  output logic                               wb_valid,
  output logic [core_pkg::reg_idx_width-1:0] wb_rd,
  output logic [core_pkg::data_width-1:0]    wb_data
);
  import core_pkg::*;

  logic [data_width-1:0] reg_file [reg_count];

  // r0 is hardwired, the result register wins over the file
  function automatic logic [data_width-1:0] read_source(
    input logic [reg_idx_width-1:0] idx
  );
    logic [data_width-1:0] value;
    if (idx == '0) begin
      value = '0;
    end else if (wb_valid && (wb_rd == idx)) begin
      value = wb_data;
    end else begin
      value = reg_file[idx];
    end
    return value;
  endfunction

  // --------------------
  // result register
  // --------------------
  // cuts the path from execute back to its own operands
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= result_valid;
    end
  end

  always_ff @(posedge clock) begin
    wb_rd   <= result_rd;
    wb_data <= result_data;
  end

  // register file, written one cycle behind the result register
  always_ff @(posedge clock) begin
    if (wb_valid) begin
      reg_file[wb_rd] <= wb_data;
    end
  end

  // --------------------
  // source reads with bypass
  // --------------------
  always_comb begin
    operands.rs1_value = read_source(operands.rs1);
    operands.rs2_value = read_source(operands.rs2);
  end

endmodule

/* maintenance/cache_maint_seq.sv */
// Cache maintenance sequencer

module cache_maint_seq (
  input  logic clock,
  input  logic reset,
  input  logic fence_start,
  input  logic dump_request,
  input  logic icache_invalidate_done,
  input  logic dcache_invalidate_done,
  input  logic l2_invalidate_done,
  output logic maint_busy,
  output logic icache_invalidate,
  output logic dcache_invalidate,
  output logic l2_invalidate,
  output logic dump_done
);
  import core_pkg::*;

  // registered done pulses
  logic icache_done_q;
  logic dcache_done_q;
  logic l2_done_q;

  fencei_state_e fencei_state;
  fencei_state_e fencei_state_next;
  dump_state_e   dump_state;
  dump_state_e   dump_state_next;

  // per-source dcache requests, merged below
  logic dcache_inv_fence;
  logic dcache_inv_fence_next;
  logic dcache_inv_dump;
  logic dcache_inv_dump_next;
  logic icache_inv_next;
  logic l2_inv_next;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      icache_done_q <= 1'b0;
      dcache_done_q <= 1'b0;
      l2_done_q     <= 1'b0;
    end else begin
      icache_done_q <= icache_invalidate_done;
      dcache_done_q <= dcache_invalidate_done;
      l2_done_q     <= l2_invalidate_done;
    end
  end

  // --------------------
  // fence.i
  // --------------------
  // both caches invalidated, dones may come in any order
  always_comb begin
    fencei_state_next     = fencei_state;
    icache_inv_next       = 1'b0;
    dcache_inv_fence_next = 1'b0;
    case (fencei_state)
      fencei_idle: begin
        if (fence_start) begin
          fencei_state_next     = fencei_invalidating;
          icache_inv_next       = 1'b1;
          dcache_inv_fence_next = 1'b1;
        end
      end
      fencei_invalidating: begin
        if (icache_done_q && dcache_done_q) begin
          fencei_state_next = fencei_idle;
        end else if (icache_done_q || dcache_done_q) begin
          fencei_state_next = fencei_half_done;
        end
      end
      fencei_half_done: begin
        // second answer closes the fence
        if (icache_done_q || dcache_done_q) begin
          fencei_state_next = fencei_idle;
        end
      end
      default: fencei_state_next = fencei_idle;
    endcase
  end

  assign maint_busy = (fencei_state != fencei_idle);

  // --------------------
  // debug dump
  // --------------------
  // dcache first, then L2, then one dump pulse
  always_comb begin
    dump_state_next      = dump_state;
    dcache_inv_dump_next = 1'b0;
    l2_inv_next          = 1'b0;
    dump_done            = 1'b0;
    case (dump_state)
      dump_idle: begin
        if (dump_request) begin
          dump_state_next = dump_before_dcache;
        end
      end
      dump_before_dcache: begin
        dcache_inv_dump_next = 1'b1;
        dump_state_next      = dump_wait_dcache;
      end
      dump_wait_dcache: begin
        if (dcache_done_q) begin
          dump_state_next = dump_before_l2;
        end
      end
      dump_before_l2: begin
        l2_inv_next     = 1'b1;
        dump_state_next = dump_wait_l2;
      end
      dump_wait_l2: begin
        if (l2_done_q) begin
          dump_state_next = dump_finish;
        end
      end
      dump_finish: begin
        // Single cycle state, so this is a pulse.
        dump_done       = 1'b1;
        dump_state_next = dump_idle;
      end
      default: dump_state_next = dump_idle;
    endcase
  end

  // state and invalidate pulse registers
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      fencei_state      <= fencei_idle;
      dump_state        <= dump_idle;
      icache_invalidate <= 1'b0;
      dcache_inv_fence  <= 1'b0;
      dcache_inv_dump   <= 1'b0;
      l2_invalidate     <= 1'b0;
    end else begin
      fencei_state      <= fencei_state_next;
      dump_state        <= dump_state_next;
      icache_invalidate <= icache_inv_next;
      dcache_inv_fence  <= dcache_inv_fence_next;
      dcache_inv_dump   <= dcache_inv_dump_next;
      l2_invalidate     <= l2_inv_next;
    end
  end

  assign dcache_invalidate = dcache_inv_fence || dcache_inv_dump;

endmodule

/* source/mini_core.sv */
// Mini core top level

module mini_core (
  input  logic                               clock,
  input  logic                               reset,
  // instruction input
  input  logic                               instr_valid,
  input  logic [core_pkg::instr_width-1:0]   instr,
  input  logic [core_pkg::pc_width-1:0]      instr_pc,
  output logic                               instr_ready,
  // redirect to fetch
  output logic                               redirect_valid,
  output logic [core_pkg::pc_width-1:0]      redirect_pc,
  // register writes
  output logic                               wb_valid,
  output logic [core_pkg::reg_idx_width-1:0] wb_rd,
  output logic [core_pkg::data_width-1:0]    wb_data,
  // cache maintenance
  input  logic                               icache_invalidate_done,
  output logic                               icache_invalidate,
  input  logic                               dcache_invalidate_done,
  output logic                               dcache_invalidate,
  input  logic                               l2_invalidate_done,
  output logic                               l2_invalidate,
  input  logic                               dump_request,
  output logic                               dump_done
);

  // --------------------
  // internal links
  // --------------------
  decoded_op_if decoded ();
  operand_if    operands ();

  // execute -> writeback
  logic                               result_valid;
  logic [core_pkg::reg_idx_width-1:0] result_rd;
  logic [core_pkg::data_width-1:0]    result_data;

  // front end hold sources
  logic hold_front;
  logic maint_busy;
  logic fence_start;

  // --------------------
  // pipeline
  // --------------------
  decode_stage decode_stage_i (
    .clock       (clock),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_pc    (instr_pc),
    .hold_front  (hold_front),
    .maint_busy  (maint_busy),
    .instr_ready (instr_ready),
    .decoded     (decoded.producer)
  );

  execute_stage execute_stage_i (
    .decoded        (decoded.consumer),
    .operands       (operands.requester),
    .result_valid   (result_valid),
    .result_rd      (result_rd),
    .result_data    (result_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .hold_front     (hold_front),
    .fence_start    (fence_start)
  );

  writeback_stage writeback_stage_i (
    .clock        (clock),
    .reset        (reset),
    .result_valid (result_valid),
    .result_rd    (result_rd),
    .result_data  (result_data),
    .operands     (operands.provider),
    .wb_valid     (wb_valid),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data)
  );

  // maintenance beside the pipeline
  cache_maint_seq cache_maint_seq_i (
    .clock                  (clock),
    .reset                  (reset),
    .fence_start            (fence_start),
    .dump_request           (dump_request),
    .icache_invalidate_done (icache_invalidate_done),
    .dcache_invalidate_done (dcache_invalidate_done),
    .l2_invalidate_done     (l2_invalidate_done),
    .maint_busy             (maint_busy),
    .icache_invalidate      (icache_invalidate),
    .dcache_invalidate      (dcache_invalidate),
    .l2_invalidate          (l2_invalidate),
    .dump_done              (dump_done)
  );

endmodule

/* test/mini_core_checker.sv */
// Top level port assertions

module mini_core_checker (
  input logic                               clock,
  input logic                               reset,
  input logic                               instr_ready,
  input logic                               redirect_valid,
  input logic                               wb_valid,
  input logic [core_pkg::reg_idx_width-1:0] wb_rd,
  input logic                               dump_done
);

  // --------------------
  // pipeline
  // --------------------
  // taken branch blocks the input in its own cycle
  redirect_blocks_input: assert property (
    @(posedge clock) disable iff (reset) redirect_valid |-> !instr_ready
  ) else $error("redirect_valid high while instr_ready is high");

  // r0 writes never leave execute
  no_write_to_r0: assert property (
    @(posedge clock) disable iff (reset) wb_valid |-> (wb_rd != '0)
  ) else $error("wb_valid high with wb_rd zero");

  // --------------------
  // maintenance
  // --------------------
  dump_done_is_pulse: assert property (
    @(posedge clock) disable iff (reset) dump_done |=> !dump_done
  ) else $error("dump_done high for two cycles in a row");

endmodule

/* test/mini_core_tb.sv */
// Mini core testbench

module mini_core_tb;
  import core_pkg::*;

  localparam int wait_limit = 400;
  // test list sits above the program words
  localparam int list_base  = 'h100;

  logic                     clock = 1'b0;
  logic                     reset = 1'b1;
  logic                     instr_valid = 1'b0;
  logic [instr_width-1:0]   instr = '0;
  logic [pc_width-1:0]      instr_pc = '0;
  logic                     instr_ready;
  logic                     redirect_valid;
  logic [pc_width-1:0]      redirect_pc;
  logic                     wb_valid;
  logic [reg_idx_width-1:0] wb_rd;
  logic [data_width-1:0]    wb_data;
  logic                     icache_invalidate_done = 1'b0;
  logic                     icache_invalidate;
  logic                     dcache_invalidate_done = 1'b0;
  logic                     dcache_invalidate;
  logic                     l2_invalidate_done = 1'b0;
  logic                     l2_invalidate;
  logic                     dump_request = 1'b0;
  logic                     dump_done;

  logic [31:0] stim_mem [512];
  integer      seed = 32'hd58b3c90;
  string       test_name = "reset";

  // fetch model state
  logic                   fetch_enable = 1'b0;
  logic [pc_width-1:0]    start_pc = '0;
  logic [pc_width-1:0]    fetch_pc = '0;
  logic                   took_word = 1'b0;
  logic [pc_width-1:0]    last_pc = '0;
  logic [instr_width-1:0] last_word = '0;

  // observed writes as {rd, data}
  logic [reg_idx_width+data_width-1:0] write_queue [$];

  // responder bookkeeping
  int   icache_pulses = 0;
  int   dcache_pulses = 0;
  int   l2_pulses = 0;
  int   dump_pulses = 0;
  int   icache_wait = 0;
  int   dcache_wait = 0;
  int   l2_wait = 0;
  logic icache_answered = 1'b0;
  logic dcache_answered = 1'b0;
  logic l2_answered = 1'b0;
  logic fence_active = 1'b0;

  always #4 clock = ~clock;

  mini_core mini_core_i (
    .clock                  (clock),
    .reset                  (reset),
    .instr_valid            (instr_valid),
    .instr                  (instr),
    .instr_pc               (instr_pc),
    .instr_ready            (instr_ready),
    .redirect_valid         (redirect_valid),
    .redirect_pc            (redirect_pc),
    .wb_valid               (wb_valid),
    .wb_rd                  (wb_rd),
    .wb_data                (wb_data),
    .icache_invalidate_done (icache_invalidate_done),
    .icache_invalidate      (icache_invalidate),
    .dcache_invalidate_done (dcache_invalidate_done),
    .dcache_invalidate      (dcache_invalidate),
    .l2_invalidate_done     (l2_invalidate_done),
    .l2_invalidate          (l2_invalidate),
    .dump_request           (dump_request),
    .dump_done              (dump_done)
  );

  bind mini_core mini_core_checker mini_core_checker_i (
    .clock          (clock),
    .reset          (reset),
    .instr_ready    (instr_ready),
    .redirect_valid (redirect_valid),
    .wb_valid       (wb_valid),
    .wb_rd          (wb_rd),
    .dump_done      (dump_done)
  );

  // --------------------
  // reporting
  // --------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Error in test %s: %s expected %0h actual %0h",
                          test_name, what, expected, actual));
    end
  endtask

  // done answer after 0..6 idle cycles
  function automatic int draw_delay();
    return 1 + ($unsigned($random(seed)) % 7);
  endfunction

  function automatic string program_name(input int index);
    case (index)
      0: return "arith";
      1: return "branch";
      2: return "fence_i";
      default: return "program";
    endcase
  endfunction

  // --------------------
  // fetch model
  // --------------------
  always @(negedge clock) begin
    // word taken at the rising edge just passed
    if (took_word) begin
      last_pc   = fetch_pc;
      last_word = instr;
      fetch_pc  = fetch_pc + 1'b1;
    end
    // target is branch pc plus sign-extended imm modulo 256
    if (redirect_valid) begin
      check_value("branch target", pc_width'(last_pc + last_word[imm_width-1:0]),
                  redirect_pc);
      fetch_pc = redirect_pc;
    end
    if (!fetch_enable) begin
      fetch_pc = start_pc;
    end
    instr_valid = fetch_enable;
    instr       = stim_mem[fetch_pc][instr_width-1:0];
    instr_pc    = fetch_pc;
    took_word   = instr_valid && instr_ready;
  end

  // --------------------
  // monitor and cache responders
  // --------------------
  always @(negedge clock) begin
    // input stays blocked until both fence.i dones were given
    if (fence_active) begin
      if (icache_answered && dcache_answered) begin
        fence_active = 1'b0;
      end else if (instr_ready) begin
        abort_run("instr_ready rose before both fence.i dones were given");
      end
    end
    if (wb_valid) begin
      write_queue.push_back({wb_rd, wb_data});
    end
    icache_invalidate_done = 1'b0;
    dcache_invalidate_done = 1'b0;
    l2_invalidate_done     = 1'b0;
    if (icache_wait > 0) begin
      icache_wait--;
      if (icache_wait == 0) begin
        icache_invalidate_done = 1'b1;
        icache_answered        = 1'b1;
      end
    end
    if (dcache_wait > 0) begin
      dcache_wait--;
      if (dcache_wait == 0) begin
        dcache_invalidate_done = 1'b1;
        dcache_answered        = 1'b1;
      end
    end
    if (l2_wait > 0) begin
      l2_wait--;
      if (l2_wait == 0) begin
        l2_invalidate_done = 1'b1;
        l2_answered        = 1'b1;
      end
    end
    // new invalidate pulses
    if (icache_invalidate) begin
      icache_pulses++;
      icache_answered = 1'b0;
      fence_active    = 1'b1;
      icache_wait     = draw_delay();
    end
    if (dcache_invalidate) begin
      dcache_pulses++;
      dcache_answered = 1'b0;
      dcache_wait     = draw_delay();
    end
    if (l2_invalidate) begin
      if (!dcache_answered) begin
        abort_run("l2_invalidate came before the dcache done was given");
      end
      l2_pulses++;
      l2_answered = 1'b0;
      l2_wait     = draw_delay();
    end
    if (dump_done) begin
      if (!l2_answered) begin
        abort_run("dump_done came before the l2 done was given");
      end
      dump_pulses++;
    end
  end

  // --------------------
  // tests
  // --------------------
  task automatic check_reset_state();
    check_value("wb_valid", 0, wb_valid);
    check_value("redirect_valid", 0, redirect_valid);
    check_value("icache_invalidate", 0, icache_invalidate);
    check_value("dcache_invalidate", 0, dcache_invalidate);
    check_value("l2_invalidate", 0, l2_invalidate);
    check_value("dump_done", 0, dump_done);
    check_value("instr_ready", 1, instr_ready);
  endtask

  task automatic wait_for_write();
    int waited;
    waited = 0;
    while (write_queue.size() == 0) begin
      if (waited == wait_limit) begin
        abort_run("timed out waiting for a register write");
      end
      @(posedge clock);
      waited++;
    end
  endtask

  // runs one program from the list and compares its writes in order
  task automatic run_program(input int index, inout int addr);
    logic [31:0]                         entry;
    logic [reg_idx_width+data_width-1:0] got;
    int                                  fences;
    int                                  icache_base;
    int                                  dcache_base;
    @(posedge clock);
    entry       = stim_mem[addr];
    addr++;
    test_name   = program_name(index);
    fences      = entry[23:16];
    icache_base = icache_pulses;
    dcache_base = dcache_pulses;
    start_pc    = entry[pc_width-1:0];
    @(posedge clock);
    fetch_enable = 1'b1;
    while (stim_mem[addr][31:24] == 8'h01) begin
      entry = stim_mem[addr];
      wait_for_write();
      got = write_queue.pop_front();
      check_value("write register", entry[23:16], got[data_width+:reg_idx_width]);
      check_value("write data", entry[15:0], got[data_width-1:0]);
      addr++;
    end
    @(posedge clock);
    fetch_enable = 1'b0;
    // two stages to drain
    repeat (4) @(negedge clock);
    check_value("extra writes", 0, write_queue.size());
    check_value("icache invalidate pulses", fences, icache_pulses - icache_base);
    check_value("dcache invalidate pulses", fences, dcache_pulses - dcache_base);
  endtask

  task automatic run_dump();
    int waited;
    int dcache_base;
    int l2_base;
    int dump_base;
    @(posedge clock);
    test_name   = "dump";
    dcache_base = dcache_pulses;
    l2_base     = l2_pulses;
    dump_base   = dump_pulses;
    // answers left over from the fence test do not count here
    dcache_answered = 1'b0;
    l2_answered     = 1'b0;
    @(negedge clock);
    dump_request = 1'b1;
    @(negedge clock);
    dump_request = 1'b0;
    waited = 0;
    while (dump_pulses == dump_base) begin
      if (waited == wait_limit) begin
        abort_run("timed out waiting for dump_done");
      end
      @(posedge clock);
      waited++;
    end
    repeat (4) @(negedge clock);
    check_value("dcache invalidate pulses", 1, dcache_pulses - dcache_base);
    check_value("l2 invalidate pulses", 1, l2_pulses - l2_base);
    check_value("dump_done pulses", 1, dump_pulses - dump_base);
  endtask

  initial begin
    int addr;
    int index;
    $readmemh("test/mini_core_input.txt", stim_mem);
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    check_reset_state();
    addr  = list_base;
    index = 0;
    // one marker per program test
    while (stim_mem[addr][31:24] == 8'h02) begin
      run_program(index, addr);
      index++;
    end
    if (index == 0) begin
      abort_run("no program tests found in the input file");
    end
    run_dump();
    $display("All tests passed");
    $finish;
  end

endmodule

/* Makefile */
# Verilator build and run for the mini core

VERILATOR  = verilator
FLAGS      = --binary --assert -j 0
LINT_FLAGS = --lint-only
TOP        = mini_core_tb
RTL_TOP    = mini_core
FILELIST   = mini_core.f
LOG        = sim.log
BIN        = obj_dir/V$(TOP)
FAIL_MSG   = Some tests failed
PASS_MSG   = All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* mini_core.f */
common/core_pkg.sv
common/decoded_op_if.sv
common/operand_if.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
pipeline/writeback_stage.sv
maintenance/cache_maint_seq.sv
source/mini_core.sv
test/mini_core_checker.sv
test/mini_core_tb.sv

/* test/mini_core_input.txt */
// program at @000, one 24-bit instruction word per pc
// list at @100, 02NNPPPP starts a test with NN fences at pc PPPP
// 01RRDDDD expects DDDD written to register RR, FF000000 ends the list
@000
320005 3440FF 165000 289800   // addi addi add sub, dependent
3A007F 314011 1D0000 2E2000   // write to r0 dropped, r0 reads zero
3D8010 122800 400000          // 16-bit wrap, then spin
@010
320003 340003 405003          // beq taken to 15
3600EE 3600EE                 // skipped
505005 380022 506004          // bne not taken, bne taken to 1b
3A00EE 3A00EE 3A00EE          // skipped
406002 3A0033 400003          // beq not taken, beq taken to 20
400000 3E00EE                 // spin at 1e, 1f skipped
3C0044 5180FD                 // bne backwards to 1e
@030
320010 600000 344001 600000   // fence.i between dependent ops
168800 400000
@100
02000000 01010005 01020004 01030009 0104FFFB
0105007F 0106FFFB 01070005 0106000B 0101007F
02000010 01010003 01020003 01040022 01050033 01060044
02020030 01010010 01020011 01030021
FF000000
